//--- design/mips_isa_pkg.sv
package mips_isa_pkg;

    // primary opcode, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J    = 6'h02, OP_JAL  = 6'h03,
        OP_BEQ     = 6'h04, OP_BNE    = 6'h05, OP_BLEZ = 6'h06, OP_BGTZ = 6'h07,
        OP_ADDI    = 6'h08, OP_COP0   = 6'h10, OP_LB   = 6'h20, OP_LH   = 6'h21,
        OP_LW      = 6'h23, OP_LBU    = 6'h24, OP_LHU  = 6'h25, OP_SB   = 6'h28,
        OP_SH      = 6'h29, OP_SW     = 6'h2b
    } opcode_e;

    // funct field of SPECIAL, eret shares the field under COP0
    typedef enum logic [5:0] {
        FN_SLL   = 6'h00, FN_SYSCALL = 6'h0c, FN_BREAK = 6'h0d, FN_ERET = 6'h18,
        FN_DIV   = 6'h1a, FN_ADD     = 6'h20, FN_SUB   = 6'h22, FN_AND  = 6'h24,
        FN_OR    = 6'h25, FN_SLT     = 6'h2a
    } funct_e;

    // REGIMM branches select on rt
    typedef enum logic [4:0] {
        RT_BLTZ = 5'h00, RT_BGEZ = 5'h01, RT_BLTZAL = 5'h10, RT_BGEZAL = 5'h11
    } regimm_e;

    typedef enum logic [7:0] {
        ALU_NOP    = 8'h00, ALU_ADD    = 8'h01, ALU_SUB    = 8'h02, ALU_OR     = 8'h03,
        ALU_AND    = 8'h04, ALU_SLT    = 8'h05, ALU_DIV    = 8'h06, ALU_LB     = 8'h10,
        ALU_LBU    = 8'h11, ALU_LH     = 8'h12, ALU_LHU    = 8'h13, ALU_LW     = 8'h14,
        ALU_SB     = 8'h18, ALU_SH     = 8'h19, ALU_SW     = 8'h1a, ALU_BEQ    = 8'h20,
        ALU_BNE    = 8'h21, ALU_BGTZ   = 8'h22, ALU_BLEZ   = 8'h23, ALU_BGEZ   = 8'h24,
        ALU_BGEZAL = 8'h25, ALU_BLTZ   = 8'h26, ALU_BLTZAL = 8'h27, ALU_J      = 8'h28,
        ALU_JAL    = 8'h29, ALU_SYSCALL = 8'h30, ALU_BREAK = 8'h31, ALU_ERET   = 8'h32,
        ALU_RI     = 8'hff  // reserved instruction marker
    } alu_op_e;

    typedef enum logic [31:0] {
        EXC_NONE    = 32'h0000_0000,
        EXC_INT     = 32'h0000_0001,
        EXC_SYSCALL = 32'h0000_0008,
        EXC_RI      = 32'h0000_000a,
        EXC_OV      = 32'h0000_000c,
        EXC_BREAK   = 32'h0000_000d,
        EXC_ERET    = 32'h0000_000e
    } exc_e;

    localparam logic [31:0] INT_VECTOR = 32'h0000_0020;
    localparam logic [31:0] EXC_VECTOR = 32'h0000_0040;

endpackage

//--- design/pipe_pkg.sv
package pipe_pkg;

    localparam int REG_AW = 5;  // 32 gprs

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } if_id_t;

    // descriptor only, operand values never travel
    typedef struct packed {
        logic [31:0]           pc;
        mips_isa_pkg::alu_op_e alu_op;
        logic                  reg1_rena;
        logic [REG_AW-1:0]     reg1_addr;
        logic                  reg2_rena;
        logic [REG_AW-1:0]     reg2_addr;
        logic [REG_AW-1:0]     wd;
        logic                  wreg;
        logic                  is_load;
    } id_ex_t;

    typedef struct packed {
        id_ex_t             op;
        mips_isa_pkg::exc_e exc;  // exception picked up in EX
    } ex_mem_t;

    typedef struct packed {
        logic [31:0]       pc;
        logic [REG_AW-1:0] wd;
        logic              wreg;
    } mem_wb_t;

endpackage

//--- design/hazard_if.sv
`timescale 1ns/1ps

interface hazard_if;
    import mips_isa_pkg::*;
    import pipe_pkg::*;

    // decode side
    alu_op_e           id_alu_op;
    logic [REG_AW-1:0] id_reg1_addr;
    logic [REG_AW-1:0] id_reg2_addr;
    logic              id_reg1_rena;
    logic              id_reg2_rena;
    // ID/EX register outputs
    logic [REG_AW-1:0] ex_reg1_addr;
    logic [REG_AW-1:0] ex_reg2_addr;
    logic              ex_reg1_rena;
    logic              ex_reg2_rena;
    logic              ex_wreg;
    logic [REG_AW-1:0] ex_wd;
    // EX/MEM register outputs
    logic              mem_rmem;
    logic [REG_AW-1:0] mem_wd;
    exc_e              exc_type;
    // exec stage
    logic              ex_ok;
    logic [31:0]       cp0_epc;

    modport stage (
        output id_alu_op, id_reg1_addr, id_reg2_addr, id_reg1_rena, id_reg2_rena,
        output ex_reg1_addr, ex_reg2_addr, ex_reg1_rena, ex_reg2_rena, ex_wreg, ex_wd,
        output mem_rmem, mem_wd, exc_type, ex_ok, cp0_epc
    );

    modport ctrl (
        input id_alu_op, id_reg1_addr, id_reg2_addr, id_reg1_rena, id_reg2_rena,
        input ex_reg1_addr, ex_reg2_addr, ex_reg1_rena, ex_reg2_rena, ex_wreg, ex_wd,
        input mem_rmem, mem_wd, exc_type, ex_ok, cp0_epc
    );

endinterface

//--- design/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type PAYLOAD_T = logic [31:0]
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     stall_i,
    input  logic     flush_i,
    input  PAYLOAD_T d_i,
    input  logic     valid_i,
    output PAYLOAD_T q_o,
    output logic     valid_o
);

    PAYLOAD_T payload_q;
    logic     valid_q;

    // only the valid bit is control state
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= valid_i & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            payload_q <= flush_i ? PAYLOAD_T'('0) : d_i;  // bubble is all zero
        end
    end

    assign q_o     = payload_q;
    assign valid_o = valid_q;

endmodule

//--- design/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
    parameter logic [31:0] RESET_PC = 32'h0000_0100
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             stall_i,
    input  logic             redirect_i,
    input  logic [31:0]      redirect_pc_i,
    output logic [31:0]      pc_o,
    input  logic [31:0]      inst_i,
    output pipe_pkg::if_id_t out_o,
    output logic             valid_o
);

    logic [31:0] pc_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;  // redirect wins over stall
        end else if (!stall_i) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // instruction port answers in the same cycle
    assign pc_o    = pc_q;
    assign out_o   = '{pc: pc_q, inst: inst_i};
    assign valid_o = ~redirect_i;  // word under a redirect is dropped

endmodule

//--- design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  pipe_pkg::if_id_t in_i,
    input  logic             valid_i,
    output pipe_pkg::id_ex_t out_o,
    hazard_if.stage          haz
);
    import mips_isa_pkg::*;
    import pipe_pkg::*;

    logic [5:0]        opcode;
    logic [5:0]        funct;
    logic [REG_AW-1:0] rs;
    logic [REG_AW-1:0] rt;
    logic [REG_AW-1:0] rd;
    logic              arith;
    id_ex_t            desc;

    assign opcode = in_i.inst[31:26];
    assign funct  = in_i.inst[5:0];
    assign rs     = in_i.inst[25:21];
    assign rt     = in_i.inst[20:16];
    assign rd     = in_i.inst[15:11];

    always_comb begin
        desc           = '0;
        desc.pc        = in_i.pc;
        desc.alu_op    = ALU_RI;  // anything not matched below
        desc.reg1_addr = rs;
        desc.reg2_addr = rt;
        arith          = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_ADD:     desc.alu_op = ALU_ADD;
                    FN_SUB:     desc.alu_op = ALU_SUB;
                    FN_AND:     desc.alu_op = ALU_AND;
                    FN_OR:      desc.alu_op = ALU_OR;
                    FN_SLT:     desc.alu_op = ALU_SLT;
                    FN_DIV:     desc.alu_op = ALU_DIV;
                    FN_SYSCALL: desc.alu_op = ALU_SYSCALL;
                    FN_BREAK:   desc.alu_op = ALU_BREAK;
                    FN_SLL:     desc.alu_op = (in_i.inst == '0) ? ALU_NOP : ALU_RI;
                    default:    desc.alu_op = ALU_RI;
                endcase
                arith = desc.alu_op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
                                            ALU_SLT, ALU_DIV};
                desc.reg1_rena = arith;
                desc.reg2_rena = arith;
                desc.wd        = rd;
                desc.wreg      = arith && (desc.alu_op != ALU_DIV);  // div writes hi/lo
            end
            OP_REGIMM: begin
                case (rt)
                    RT_BLTZ:   desc.alu_op = ALU_BLTZ;
                    RT_BGEZ:   desc.alu_op = ALU_BGEZ;
                    RT_BLTZAL: desc.alu_op = ALU_BLTZAL;
                    RT_BGEZAL: desc.alu_op = ALU_BGEZAL;
                    default:   desc.alu_op = ALU_RI;
                endcase
                desc.reg1_rena = (desc.alu_op != ALU_RI);
                desc.wd        = 5'd31;  // link register
                desc.wreg      = desc.alu_op inside {ALU_BLTZAL, ALU_BGEZAL};
            end
            OP_J:    desc.alu_op = ALU_J;
            OP_JAL: begin
                desc.alu_op = ALU_JAL;
                desc.wd     = 5'd31;
                desc.wreg   = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                desc.alu_op    = (opcode == OP_BEQ) ? ALU_BEQ : ALU_BNE;
                desc.reg1_rena = 1'b1;
                desc.reg2_rena = 1'b1;
            end
            OP_BLEZ, OP_BGTZ: begin
                desc.alu_op    = (opcode == OP_BLEZ) ? ALU_BLEZ : ALU_BGTZ;
                desc.reg1_rena = 1'b1;
            end
            OP_ADDI: begin
                desc.alu_op    = ALU_ADD;
                desc.reg1_rena = 1'b1;
                desc.wd        = rt;
                desc.wreg      = 1'b1;
            end
            OP_COP0: begin
                if (in_i.inst[25] && funct == FN_ERET) begin
                    desc.alu_op = ALU_ERET;
                end
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
                case (opcode)
                    OP_LB:   desc.alu_op = ALU_LB;
                    OP_LH:   desc.alu_op = ALU_LH;
                    OP_LBU:  desc.alu_op = ALU_LBU;
                    OP_LHU:  desc.alu_op = ALU_LHU;
                    default: desc.alu_op = ALU_LW;
                endcase
                desc.reg1_rena = 1'b1;  // base
                desc.wd        = rt;
                desc.wreg      = 1'b1;
                desc.is_load   = 1'b1;
            end
            OP_SB, OP_SH, OP_SW: begin
                desc.alu_op    = (opcode == OP_SB) ? ALU_SB :
                                 (opcode == OP_SH) ? ALU_SH : ALU_SW;
                desc.reg1_rena = 1'b1;
                desc.reg2_rena = 1'b1;  // store data
            end
            default: desc.alu_op = ALU_RI;
        endcase
        desc.wreg = desc.wreg && (desc.wd != '0);  // $0 never a producer
    end

    assign out_o = valid_i ? desc : id_ex_t'('0);

    assign haz.id_alu_op    = out_o.alu_op;
    assign haz.id_reg1_addr = out_o.reg1_addr;
    assign haz.id_reg2_addr = out_o.reg2_addr;
    assign haz.id_reg1_rena = out_o.reg1_rena;
    assign haz.id_reg2_rena = out_o.reg2_rena;

endmodule

//--- design/exec_stage.sv
`timescale 1ns/1ps

module exec_stage #(
    parameter int DIV_CYCLES = 4
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  pipe_pkg::id_ex_t  in_i,
    input  logic              valid_i,
    input  logic              stall_i,
    output pipe_pkg::ex_mem_t out_o,
    hazard_if.stage           haz
);
    import mips_isa_pkg::*;
    import pipe_pkg::*;

    localparam int CW = $clog2(DIV_CYCLES) + 1;

    logic [CW-1:0] div_cnt;
    logic          is_div;
    logic          ex_ok;
    exc_e          exc;
    logic [31:0]   epc_q;

    assign is_div = valid_i && (in_i.alu_op == ALU_DIV);
    assign ex_ok  = !is_div || (div_cnt == CW'(DIV_CYCLES - 1));  // last cycle of the divide

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || !is_div) begin
            div_cnt <= '0;
        end else if (!ex_ok) begin
            div_cnt <= div_cnt + 1'b1;
        end else if (!stall_i) begin
            div_cnt <= '0;  // result handed to EX/MEM
        end
    end

    always_comb begin
        exc = EXC_NONE;
        if (valid_i) begin
            case (in_i.alu_op)
                ALU_SYSCALL: exc = EXC_SYSCALL;
                ALU_BREAK:   exc = EXC_BREAK;
                ALU_ERET:    exc = EXC_ERET;
                ALU_RI:      exc = EXC_RI;
                default:     exc = EXC_NONE;
            endcase
        end
    end

    // faulting pc follows its instruction into EX/MEM, where the exception commits
    always_ff @(posedge clk_i) begin
        if (!stall_i && (exc inside {EXC_SYSCALL, EXC_BREAK, EXC_RI})) begin
            epc_q <= in_i.pc;
        end
    end

    assign out_o       = '{op: in_i, exc: exc};
    assign haz.ex_ok   = ex_ok;
    assign haz.cp0_epc = epc_q;

endmodule

//--- design/stall_flush_controller.sv
`timescale 1ns/1ps

module stall_flush_controller (
    hazard_if.ctrl haz,
    input  logic        inst_stall_i,
    input  logic        data_stall_i,

    output logic        if_stall_o,
    output logic        if2id_stall_o,
    output logic        id2ex_stall_o,
    output logic        ex2mem_stall_o,
    output logic        mem2wb_stall_o,

    output logic        id2ex_flush_o,
    output logic        ex2mem_flush_o,

    output logic        flush_o,
    output logic [31:0] new_pc_o
);
    import mips_isa_pkg::*;

    logic stall_all;
    logic read_after_load;
    logic is_branch_inst;
    logic is_mem_inst;
    logic branch_stall;

    // memory ports busy or divide still running
    assign stall_all = inst_stall_i | data_stall_i | ~haz.ex_ok;

    // load sitting in MEM feeds the instruction in EX
    assign read_after_load = haz.mem_rmem & (
        (haz.ex_reg1_rena & (haz.ex_reg1_addr == haz.mem_wd)) |
        (haz.ex_reg2_rena & (haz.ex_reg2_addr == haz.mem_wd))
    );

    assign is_branch_inst = haz.id_alu_op inside {ALU_BEQ, ALU_BNE, ALU_BGTZ, ALU_BLEZ,
                                                  ALU_BGEZ, ALU_BGEZAL, ALU_BLTZ,
                                                  ALU_BLTZAL};
    assign is_mem_inst    = haz.id_alu_op inside {ALU_LB, ALU_LBU, ALU_LH, ALU_LHU,
                                                  ALU_LW, ALU_SB, ALU_SH, ALU_SW};

    // decode needs the operand now, EX has not produced it yet
    assign branch_stall = (is_branch_inst | is_mem_inst) & haz.ex_wreg & (
        (haz.id_reg1_rena & (haz.id_reg1_addr == haz.ex_wd)) |
        (haz.id_reg2_rena & (haz.id_reg2_addr == haz.ex_wd))
    );

    assign if_stall_o     = stall_all | read_after_load | branch_stall;
    assign if2id_stall_o  = stall_all | read_after_load | branch_stall;
    assign id2ex_stall_o  = stall_all | read_after_load;
    assign ex2mem_stall_o = stall_all;
    assign mem2wb_stall_o = stall_all;

    assign id2ex_flush_o  = branch_stall & ~stall_all;     // bubble behind the branch
    assign ex2mem_flush_o = read_after_load & ~stall_all;  // bubble behind the load

    // exception waits in EX/MEM until nothing holds the pipe
    assign flush_o = (haz.exc_type != EXC_NONE) & ~stall_all;

    always_comb begin
        case (haz.exc_type)
            EXC_INT:                                  new_pc_o = INT_VECTOR;
            EXC_SYSCALL, EXC_RI, EXC_OV, EXC_BREAK:   new_pc_o = EXC_VECTOR;
            EXC_ERET:                                 new_pc_o = haz.cp0_epc;
            default:                                  new_pc_o = 32'h0;
        endcase
    end

endmodule

//--- design/mips_pipe_ctrl_top.sv
`timescale 1ns/1ps

module mips_pipe_ctrl_top #(
    parameter logic [31:0] RESET_PC   = 32'h0000_0100,
    parameter int          DIV_CYCLES = 4
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    output logic [31:0] pc_o,
    input  logic [31:0] inst_i,
    input  logic        inst_stall_i,
    input  logic        data_stall_i,
    output logic        retire_valid_o,
    output logic [31:0] retire_pc_o,
    output logic        flush_o
);
    import mips_isa_pkg::*;
    import pipe_pkg::*;

    if_id_t  if_d, if_id_q;
    id_ex_t  id_d, id_ex_q;
    ex_mem_t ex_d, ex_mem_q;
    mem_wb_t mem_d, mem_wb_q;
    logic    if_valid, if_id_valid, id_ex_valid, ex_mem_valid, mem_wb_valid;

    logic        if_stall, if2id_stall, id2ex_stall, ex2mem_stall, mem2wb_stall;
    logic        id2ex_flush, ex2mem_flush;
    logic        flush;
    logic [31:0] new_pc;

    hazard_if haz_bus ();

    fetch_stage #(.RESET_PC(RESET_PC)) fetch_i (
        .clk_i, .rst_n_i, .stall_i(if_stall), .redirect_i(flush), .redirect_pc_i(new_pc),
        .pc_o, .inst_i, .out_o(if_d), .valid_o(if_valid)
    );

    // exception flush overrides any stall on the younger registers
    stage_reg #(.PAYLOAD_T(if_id_t)) if_id_reg_i (
        .clk_i, .rst_n_i, .stall_i(if2id_stall & ~flush), .flush_i(flush),
        .d_i(if_d), .valid_i(if_valid), .q_o(if_id_q), .valid_o(if_id_valid)
    );

    decode_stage decode_i (.in_i(if_id_q), .valid_i(if_id_valid), .out_o(id_d), .haz(haz_bus));

    stage_reg #(.PAYLOAD_T(id_ex_t)) id_ex_reg_i (
        .clk_i, .rst_n_i, .stall_i(id2ex_stall & ~flush), .flush_i(flush | id2ex_flush),
        .d_i(id_d), .valid_i(if_id_valid), .q_o(id_ex_q), .valid_o(id_ex_valid)
    );

    exec_stage #(.DIV_CYCLES(DIV_CYCLES)) exec_i (
        .clk_i, .rst_n_i, .in_i(id_ex_q), .valid_i(id_ex_valid),
        .stall_i(id2ex_stall | flush), .out_o(ex_d), .haz(haz_bus)
    );

    stage_reg #(.PAYLOAD_T(ex_mem_t)) ex_mem_reg_i (
        .clk_i, .rst_n_i, .stall_i(ex2mem_stall & ~flush), .flush_i(flush | ex2mem_flush),
        .d_i(ex_d), .valid_i(id_ex_valid), .q_o(ex_mem_q), .valid_o(ex_mem_valid)
    );

    assign mem_d = '{pc: ex_mem_q.op.pc, wd: ex_mem_q.op.wd, wreg: ex_mem_q.op.wreg};

    // excepting instruction itself moves on and retires
    stage_reg #(.PAYLOAD_T(mem_wb_t)) mem_wb_reg_i (
        .clk_i, .rst_n_i, .stall_i(mem2wb_stall), .flush_i(1'b0),
        .d_i(mem_d), .valid_i(ex_mem_valid), .q_o(mem_wb_q), .valid_o(mem_wb_valid)
    );

    // hazard fields taken from the stage registers, bubbles masked off
    assign haz_bus.ex_reg1_addr = id_ex_q.reg1_addr;
    assign haz_bus.ex_reg2_addr = id_ex_q.reg2_addr;
    assign haz_bus.ex_reg1_rena = id_ex_q.reg1_rena & id_ex_valid;
    assign haz_bus.ex_reg2_rena = id_ex_q.reg2_rena & id_ex_valid;
    assign haz_bus.ex_wreg      = id_ex_q.wreg & id_ex_valid;
    assign haz_bus.ex_wd        = id_ex_q.wd;
    assign haz_bus.mem_rmem     = ex_mem_q.op.is_load & ex_mem_valid;
    assign haz_bus.mem_wd       = ex_mem_q.op.wd;
    assign haz_bus.exc_type     = ex_mem_valid ? ex_mem_q.exc : EXC_NONE;

    stall_flush_controller ctrl_i (
        .haz(haz_bus), .inst_stall_i, .data_stall_i,
        .if_stall_o(if_stall), .if2id_stall_o(if2id_stall), .id2ex_stall_o(id2ex_stall),
        .ex2mem_stall_o(ex2mem_stall), .mem2wb_stall_o(mem2wb_stall),
        .id2ex_flush_o(id2ex_flush), .ex2mem_flush_o(ex2mem_flush),
        .flush_o(flush), .new_pc_o(new_pc)
    );

    assign retire_valid_o = mem_wb_valid & ~mem2wb_stall;  // one pulse as WB releases
    assign retire_pc_o    = mem_wb_q.pc;
    assign flush_o        = flush;

endmodule

//--- verif/mips_pipe_ctrl_assert.sv
`timescale 1ns/1ps

module mips_pipe_ctrl_assert (
    input logic        clk_i,
    input logic        rst_n_i,
    input logic        flush_i,
    input logic [31:0] new_pc_i,
    input logic [31:0] epc_i,
    input logic [4:0]  stall_i,
    input logic        if_id_valid_i,
    input logic        id_ex_valid_i,
    input logic        ex_mem_valid_i
);
    import mips_isa_pkg::*;

    logic reset_seen_q;  // reset already low on the previous edge

    always_ff @(posedge clk_i) begin
        reset_seen_q <= ~rst_n_i;
    end

    // younger registers take a bubble, never the instruction behind them
    flush_drops_loads: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        flush_i |=> (!if_id_valid_i && !id_ex_valid_i && !ex_mem_valid_i)
    ) else $error("flushed stage register picked up a valid instruction");

    flush_target_legal: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        flush_i |-> (new_pc_i == INT_VECTOR || new_pc_i == EXC_VECTOR || new_pc_i == epc_i)
    ) else $error("redirect target %h is neither a vector nor the epc", new_pc_i);

    stalls_quiet_in_reset: assert property (
        @(posedge clk_i) (!rst_n_i && reset_seen_q) |-> (stall_i == 5'b0)
    ) else $error("stall output high while in reset");

endmodule

//--- verif/mips_pipe_ctrl_tb.sv
`timescale 1ns/1ps

module mips_pipe_ctrl_tb;
    import mips_isa_pkg::*;

    localparam logic [31:0] RESET_PC          = 32'h0000_0100;
    localparam int          DIV_CYCLES        = 4;
    localparam int          CLK_PERIOD        = 100;
    localparam int          RESET_CYCLES      = 8;
    localparam int          IMG_WORDS         = 256;  // image covers 0x000..0x3fc
    localparam int          MAX_EXP           = 64;
    localparam int          NUM_PASSES        = 2;    // quiet pass and a pass with random stalls
    localparam int          CYCLES_PER_RETIRE = 40;
    localparam logic [31:0] END_MARK          = 32'hffff_ffff;

    logic        clk;
    logic        rst_n;
    logic [31:0] pc;
    logic [31:0] inst;
    logic        inst_stall = 1'b0;
    logic        data_stall = 1'b0;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic        flush;

    logic [31:0] pat [0:IMG_WORDS+MAX_EXP-1];  // image followed by the expected retire pcs
    int          n_exp;
    int          exp_flush;
    logic [31:0] sys_pc;                        // pc of the syscall
    bit          loaded;
    bit          checking;
    bit          stall_en;
    bit          redirect_pending;
    int          ret_idx;
    int          n_flush;
    int          value_errs;
    int          other_errs;

    mips_pipe_ctrl_top #(
        .RESET_PC   (RESET_PC),
        .DIV_CYCLES (DIV_CYCLES)
    ) mips_pipe_ctrl_top_i (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .pc_o           (pc),
        .inst_i         (inst),
        .inst_stall_i   (inst_stall),
        .data_stall_i   (data_stall),
        .retire_valid_o (retire_valid),
        .retire_pc_o    (retire_pc),
        .flush_o        (flush)
    );

    // controller outputs as wired inside the top
    bind mips_pipe_ctrl_top mips_pipe_ctrl_assert ctrl_assert_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush),
        .new_pc_i       (new_pc),
        .epc_i          (haz_bus.cp0_epc),
        .stall_i        ({if_stall, if2id_stall, id2ex_stall, ex2mem_stall, mem2wb_stall}),
        .if_id_valid_i  (if_id_valid),
        .id_ex_valid_i  (id_ex_valid),
        .ex_mem_valid_i (ex_mem_valid)
    );

    // instruction memory answers in the same cycle as pc_o
    assign inst = pat[{1'b0, pc[9:2]}];

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (stall_en) begin
            inst_stall <= ($urandom % 5) == 0;
            data_stall <= ($urandom % 6) == 0;
        end else begin
            inst_stall <= 1'b0;
            data_stall <= 1'b0;
        end
    end

    task automatic load_patterns();
        for (int a = 0; a < IMG_WORDS; a++) begin
            pat[a] = {6'h08, 5'd0, 5'(a), 16'(a * 4)};  // addi rN,$0,<byte address>
        end
        for (int e = 0; e < MAX_EXP; e++) begin
            pat[IMG_WORDS + e] = END_MARK;
        end
        $readmemh("verif/mips_pipe_ctrl_patterns.mem", pat);
        n_exp  = 0;
        sys_pc = END_MARK;
        while (n_exp < MAX_EXP && pat[IMG_WORDS + n_exp] != END_MARK) begin
            n_exp++;
        end
        // the syscall is the retire just before the handler entry
        for (int k = 0; k + 1 < n_exp; k++) begin
            if (sys_pc == END_MARK && pat[IMG_WORDS + k + 1] == EXC_VECTOR) begin
                sys_pc = pat[IMG_WORDS + k];
            end
        end
        // every break in the retire order is one redirect
        exp_flush = 0;
        for (int k = 0; k + 1 < n_exp; k++) begin
            if (pat[IMG_WORDS + k + 1] != pat[IMG_WORDS + k] + 32'd4) begin
                exp_flush++;
            end
        end
        // a closing syscall flushes before its own retire
        if (n_exp > 0 && pat[IMG_WORDS + n_exp - 1] == sys_pc) begin
            exp_flush++;
        end
        if (n_exp == 0 || sys_pc == END_MARK) begin
            $display("pattern file holds no usable expected retire sequence");
            other_errs++;
        end
        loaded = 1'b1;
    endtask

    task automatic check_reset_state();
        if (pc !== RESET_PC) begin
            $display("[FAIL] pc_o: got %h, expected %h around reset", pc, RESET_PC);
            value_errs++;
        end
        if (retire_valid !== 1'b0) begin
            $display("[FAIL] retire_valid_o: got %h, expected 0 around reset", retire_valid);
            value_errs++;
        end
        if (flush !== 1'b0) begin
            $display("[FAIL] flush_o: got %h, expected 0 around reset", flush);
            value_errs++;
        end
    endtask

    task automatic check_retire();
        logic [31:0] expected;
        if (inst_stall || data_stall) begin
            $display("retire pulse at pc %h while a memory stall input was high", retire_pc);
            other_errs++;
        end
        if (retire_pc == sys_pc + 32'd4) begin
            $display("instruction behind the syscall retired at pc %h", retire_pc);
            other_errs++;
        end
        if (ret_idx < n_exp) begin
            expected = pat[IMG_WORDS + ret_idx];
            if (retire_pc !== expected) begin
                $display("[FAIL] retire_pc_o: got %h, expected %h at retire %0d",
                         retire_pc, expected, ret_idx);
                value_errs++;
            end
            ret_idx++;
        end
    endtask

    always @(negedge clk) begin : monitor
        logic [31:0] target;
        if (checking) begin
            if (redirect_pending) begin
                // odd flushes enter the handler, even ones return
                target = (n_flush % 2 == 1) ? EXC_VECTOR : sys_pc;
                if (pc !== target) begin
                    $display("[FAIL] pc_o after flush: got %h, expected %h", pc, target);
                    value_errs++;
                end
                redirect_pending = 1'b0;
            end
            if (flush) begin
                n_flush++;
                redirect_pending = 1'b1;
            end
            if (retire_valid) begin
                check_retire();
            end
        end
    end

    task automatic run_pass(input bit with_stalls);
        checking         = 1'b0;
        stall_en         = 1'b0;
        ret_idx          = 0;
        n_flush          = 0;
        redirect_pending = 1'b0;
        @(posedge clk);
        rst_n <= 1'b0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_reset_state();  // first cycle still shows the previous state
            end
            @(posedge clk);
        end
        rst_n    <= 1'b1;
        checking  = 1'b1;
        @(negedge clk);
        check_reset_state();
        stall_en = with_stalls;
        wait (ret_idx == n_exp);
        checking = 1'b0;
        stall_en = 1'b0;
        if (n_flush != exp_flush) begin
            $display("saw %0d exception flushes, expected %0d", n_flush, exp_flush);
            other_errs++;
        end
    endtask

    initial begin
        int seed_ret;
        rst_n    = 1'b0;
        seed_ret = $urandom(32'h8cfe);
        load_patterns();
        for (int p = 0; p < NUM_PASSES; p++) begin
            run_pass(p == 1);
        end
        $display("errors: %0d value mismatches, %0d other failures, %0d retires per pass",
                 value_errs, other_errs, n_exp);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // watchdog sized from the expected retire count
    initial begin
        int limit;
        wait (loaded);
        limit = NUM_PASSES * (RESET_CYCLES + 2 + CYCLES_PER_RETIRE * n_exp);
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, %0d of %0d retires seen",
                 limit, ret_idx, n_exp);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- verif/mips_pipe_ctrl_patterns.mem
// image: @word address (byte address / 4), then one instruction word per line
// expected: from @100 the retire pcs in program order, ffffffff or end of file closes the list
@10
20090009  // 0x040 addi $9,$0,9
00000000  // 0x044 nop
42000018  // 0x048 eret
200a000a  // 0x04c addi $10,$0,10 never retires
@40
20010005  // 0x100 addi $1,$0,5
20020007  // 0x104 addi $2,$0,7
00221820  // 0x108 add $3,$1,$2
8c640000  // 0x10c lw $4,0($3) base from EX
00812820  // 0x110 add $5,$4,$1 load-use
20060001  // 0x114 addi $6,$0,1
10c50000  // 0x118 beq $6,$5 operand still in EX
0022001a  // 0x11c div $1,$2
20070002  // 0x120 addi $7,$0,2
ace70000  // 0x124 sw $7,0($7)
0000000c  // 0x128 syscall
20080008  // 0x12c addi $8,$0,8 never retires
@100
00000100 00000104 00000108 0000010c 00000110
00000114 00000118 0000011c 00000120 00000124
00000128 00000040 00000044 00000048 00000128

//--- list.f
design/mips_isa_pkg.sv
design/pipe_pkg.sv
design/hazard_if.sv
design/stage_reg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/exec_stage.sv
design/stall_flush_controller.sv
design/mips_pipe_ctrl_top.sv
verif/mips_pipe_ctrl_assert.sv
verif/mips_pipe_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run with Verilator, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module mips_pipe_ctrl_tb -f list.f \
    -o mips_pipe_ctrl_sim > sim.log 2>&1 \
    && ./obj_dir/mips_pipe_ctrl_sim >> sim.log 2>&1
grep -q "Regression passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
